//--- alut_top.f
hw/alut_pkg.sv
hw/alut_mem.sv
hw/alut_addr_checker.sv
hw/alut_age_checker.sv
hw/alut_top.sv
test/alut_chk.sv
test/alut_tb.sv

//--- Bender.yml
package:
  name: alut

sources:
  - hw/alut_pkg.sv
  - hw/alut_mem.sv
  - hw/alut_addr_checker.sv
  - hw/alut_age_checker.sv
  - hw/alut_top.sv
  - target: test
    files:
      - test/alut_chk.sv
      - test/alut_tb.sv

//--- test/alut_tb.sv
// directed testbench for the MAC lookup table, drives alut_top and checks it against a table model
module alut_tb;
   import alut_pkg::*;

   localparam int depth = 256;   // table entries to match hash_w
   localparam int tmo   = 16;    // cycles allowed for a result

   logic              pclk17;
   logic              rst_n;
   logic              check_req;
   alut_req_t         req;
   logic              age_en;
   logic [time_w-1:0] max_age;
   logic              result_valid;
   alut_result_t      result;
   logic              busy;
   logic              ready;

   alut_entry_t      model [depth];       // expected table contents
   bit               used_hash [depth];   // hashes already handed out
   logic [mac_w-1:0] mac_a, mac_b;        // shared between tests

   alut_top #(.depth(depth)) dut (
      .pclk17       (pclk17),
      .rst_n        (rst_n),
      .check_req    (check_req),
      .req          (req),
      .age_en       (age_en),
      .max_age      (max_age),
      .result_valid (result_valid),
      .result       (result),
      .busy         (busy),
      .ready        (ready)
   );

   // ------------------------------------------------------------------------
   // assertion modules bound into both checkers
   // ------------------------------------------------------------------------
   bind alut_addr_checker alut_chk u_chk_add (
      .pclk17(pclk17), .rst_n(rst_n), .accept(accept), .busy(busy),
      .result_valid(result_valid), .ready(ready), .age_write(1'b0));
   bind alut_age_checker alut_chk u_chk_age (
      .pclk17(pclk17), .rst_n(rst_n), .accept(1'b0), .busy(busy),
      .result_valid(1'b0), .ready(ready), .age_write(write));

   initial pclk17 = 1'b0;
   always #20 pclk17 = ~pclk17;   // period 40

   // ------------------------------------------------------------------------
   // model and helpers
   // ------------------------------------------------------------------------
   function automatic logic [hash_w-1:0] fold_mac(input logic [mac_w-1:0] m);
      return m[47:40] ^ m[39:32] ^ m[31:24] ^ m[23:16] ^ m[15:8] ^ m[7:0];   // byte xor
   endfunction

   // random MAC whose hash no earlier draw has taken
   function automatic logic [mac_w-1:0] fresh_mac();
      logic [mac_w-1:0] m;
      m = {16'($urandom), $urandom};
      while (used_hash[fold_mac(m)])
         m = {16'($urandom), $urandom};
      used_hash[fold_mac(m)] = 1'b1;
      return m;
   endfunction

   function automatic alut_req_t make_req(input logic [mac_w-1:0] dst,
                                          input logic [mac_w-1:0] src,
                                          input logic [port_w-1:0] port);
      return '{dst_mac: dst, src_mac: src, src_port: port};
   endfunction

   function automatic alut_result_t predict(input logic [mac_w-1:0] dst);
      alut_entry_t  e;
      alut_result_t p;
      e      = model[fold_mac(dst)];
      p.hit  = e.valid && (e.mac == dst);   // full MAC must match
      p.port = p.hit ? e.port : '0;
      return p;
   endfunction

   function automatic void learn(input alut_req_t r);
      model[fold_mac(r.src_mac)] = '{valid: 1'b1, stamp: '0, port: r.src_port, mac: r.src_mac};
   endfunction

   // failed assertions in both bound checkers
   function automatic int unsigned assert_fails();
      return dut.u_addr_checker.u_chk_add.fails + dut.u_age_checker.u_chk_age.fails;
   endfunction

   task automatic fail_stop(input string what);
      $display("%s", what);
      $display("TESTS FAILED");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic check_result(input string name, input alut_result_t got, input alut_result_t exp);
      if (got !== exp)
         fail_stop($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
   endtask

   task automatic check_level(input string name, input logic got, input logic exp);
      if (got !== exp)
         fail_stop($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
   endtask

   task automatic step();
      @(posedge pclk17);
      #2;   // drive point
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge pclk17);
   endtask

   // assertion failures stop the run half a cycle later
   always @(negedge pclk17)
   begin
      if (assert_fails() != 0)
         fail_stop("an assertion in a bound checker failed");
   end

   // one request with its result expected on the 3rd edge after the request edge
   task automatic do_request(input alut_req_t r);
      alut_result_t exp;
      int           n;
      exp = predict(r.dst_mac);
      step();
      check_req = 1'b1;
      req       = r;
      step();   // request edge passed
      check_req = 1'b0;
      for (n = 1; n <= tmo; n++)
      begin
         @(negedge pclk17);
         if (result_valid) break;
      end
      if (n > tmo) fail_stop("no result_valid pulse after a lookup request");
      if (n != 3) fail_stop($sformatf("ERR result_valid latency got 0x%0h expected 0x3", n));
      check_result("result", result, exp);
      @(negedge pclk17);
      check_level("result_valid", result_valid, 1'b0);   // one cycle only
      check_level("busy", busy, 1'b0);
      learn(r);
   endtask

   // ------------------------------------------------------------------------
   // directed tests
   // ------------------------------------------------------------------------
   task automatic clear_test();
      int n;
      repeat (10) @(posedge pclk17);   // reset held 10 cycles
      check_level("ready", ready, 1'b0);
      check_level("busy", busy, 1'b0);
      check_level("result_valid", result_valid, 1'b0);
      #2;
      rst_n = 1'b1;
      for (n = 1; n <= depth + 8; n++)
      begin
         @(negedge pclk17);
         if (ready) break;
      end
      if (n > depth + 8) fail_stop("ready did not rise after the clear sweep");
      if (n <= depth) fail_stop("ready rose before every entry was cleared");
      repeat (3) do_request(make_req(fresh_mac(), fresh_mac(), 2'd1));   // empty table
   endtask

   task automatic learn_test();
      mac_a = fresh_mac();
      mac_b = fresh_mac();
      do_request(make_req(fresh_mac(), mac_a, 2'd2));   // A on port 2
      do_request(make_req(mac_a, fresh_mac(), 2'd0));
      do_request(make_req(fresh_mac(), mac_b, 2'd1));   // B on port 1
      do_request(make_req(mac_a, fresh_mac(), 2'd0));
      do_request(make_req(mac_b, fresh_mac(), 2'd0));
   endtask

   task automatic collision_test();
      logic [mac_w-1:0] mac_c, mac_d;
      mac_c = fresh_mac();
      mac_d = mac_c ^ 48'h5a5a_0000_0000;   // same flip in two bytes keeps the fold
      do_request(make_req(fresh_mac(), mac_c, 2'd1));
      do_request(make_req(fresh_mac(), mac_d, 2'd3));   // replaces C
      do_request(make_req(mac_c, fresh_mac(), 2'd0));
      do_request(make_req(mac_d, fresh_mac(), 2'd0));
   endtask

   task automatic dropped_request_test();
      alut_req_t    r1, r2;
      alut_result_t exp;
      int           pulses, first;
      r1     = make_req(mac_a, fresh_mac(), 2'd1);
      r2     = make_req(mac_b, fresh_mac(), 2'd3);
      exp    = predict(r1.dst_mac);
      pulses = 0;
      first  = 0;
      step();
      check_req = 1'b1;
      req       = r1;
      step();
      req = r2;   // arrives while busy
      check_level("busy", busy, 1'b1);
      step();
      check_req = 1'b0;
      for (int n = 2; n <= 12; n++)   // observation window counted from r1
      begin
         @(negedge pclk17);
         if (result_valid)
         begin
            pulses++;
            if (first == 0) first = n;
            check_result("result", result, exp);
         end
      end
      if (pulses != 1) fail_stop($sformatf("ERR result_valid pulses got 0x%0h expected 0x1", pulses));
      if (first != 3) fail_stop($sformatf("ERR result_valid latency got 0x%0h expected 0x3", first));
      learn(r1);   // r2 leaves no trace
      do_request(make_req(r2.src_mac, fresh_mac(), 2'd0));
      do_request(make_req(r1.src_mac, fresh_mac(), 2'd0));
   endtask

   task automatic aging_test();
      logic [mac_w-1:0] mac_e;
      wait_cycles(1000);   // aging still off
      do_request(make_req(mac_a, fresh_mac(), 2'd0));
      step();
      max_age = 200;
      age_en  = 1'b1;
      mac_e   = fresh_mac();
      do_request(make_req(mac_e, mac_e, 2'd3));          // learn at a known time
      do_request(make_req(mac_e, fresh_mac(), 2'd0));   // still young
      wait_cycles(200 + 4 * depth);
      for (int i = 0; i < depth; i++)
         model[i].valid = 1'b0;   // all entries now older than max_age
      do_request(make_req(mac_e, fresh_mac(), 2'd0));
      do_request(make_req(mac_e, mac_e, 2'd1));          // relearn
      do_request(make_req(mac_e, fresh_mac(), 2'd0));
   endtask

   initial
   begin
      void'($urandom(45));   // single seed for the run
      rst_n     = 1'b0;
      check_req = 1'b0;
      req       = '0;
      age_en    = 1'b0;
      max_age   = '0;
      for (int i = 0; i < depth; i++)
      begin
         model[i]     = '0;
         used_hash[i] = 1'b0;
      end
      clear_test();
      learn_test();
      collision_test();
      dropped_request_test();
      aging_test();
      if (assert_fails() != 0)
         fail_stop("an assertion in a bound checker failed");
      else
      begin
         $display("TESTS PASSED");
         $finish;
      end
   end

endmodule

//--- test/alut_chk.sv
// assertion module bound into the address checker and the age checker
module alut_chk (
   input logic pclk17,
   input logic rst_n,
   input logic accept,         // request taken by the address checker
   input logic busy,           // address checker sequencing
   input logic result_valid,
   input logic ready,          // clear sweep done
   input logic age_write       // age port write strobe
);

   int unsigned fails = 0;     // failed assertions so far

   // ------------------------------------------------------------------------
   // address checker timing
   // ------------------------------------------------------------------------
   a_result_latency: assert property (@(posedge pclk17) disable iff (!rst_n)
      accept |=> !result_valid ##1 !result_valid ##1 result_valid)
      else
      begin
         fails++;
         $error("result_valid not exactly 3 cycles after an accepted request");
      end

   a_result_busy: assert property (@(posedge pclk17) disable iff (!rst_n)
      result_valid |-> $past(busy))   // strobe ends a busy sequence
      else
      begin
         fails++;
         $error("result_valid without busy in the cycle before");
      end

   // ------------------------------------------------------------------------
   // table ownership and clear
   // ------------------------------------------------------------------------
   a_age_quiet: assert property (@(posedge pclk17) disable iff (!rst_n)
      !(age_write && busy))
      else
      begin
         fails++;
         $error("age port wrote the table while busy");
      end

   a_ready_stays: assert property (@(posedge pclk17) disable iff (!rst_n)
      !$fell(ready))   // only reset brings it down
      else
      begin
         fails++;
         $error("ready fell outside reset");
      end

endmodule

//--- hw/alut_top.sv
// top of the MAC lookup table: entry RAM, address checker and age checker wired together
module alut_top #(
   parameter int depth = 256                       // table entries, hash_w wide index
) (
   input  logic                        pclk17,
   input  logic                        rst_n,
   input  logic                        check_req,  // lookup strobe
   input  alut_pkg::alut_req_t         req,
   input  logic                        age_en,
   input  logic [alut_pkg::time_w-1:0] max_age,
   output logic                        result_valid,
   output alut_pkg::alut_result_t      result,
   output logic                        busy,
   output logic                        ready
);
   import alut_pkg::*;

   // ------------------------------------------------------------------------
   // memory ports
   // ------------------------------------------------------------------------
   logic [hash_w-1:0] addr_add, addr_age;
   logic              write_add, write_age;
   alut_entry_t       wdata_add, wdata_age;
   alut_entry_t       rdata_add, rdata_age;
   logic [time_w-1:0] curr_time;   // age checker to address checker

   alut_mem #(.depth(depth)) u_mem (
      .pclk17    (pclk17),
      .addr_add  (addr_add),
      .write_add (write_add),
      .wdata_add (wdata_add),
      .addr_age  (addr_age),
      .write_age (write_age),
      .wdata_age (wdata_age),
      .rdata_add (rdata_add),
      .rdata_age (rdata_age)
   );

   alut_addr_checker u_addr_checker (
      .pclk17       (pclk17),
      .rst_n        (rst_n),
      .check_req    (check_req),
      .req          (req),
      .ready        (ready),
      .curr_time    (curr_time),
      .rdata        (rdata_add),
      .addr         (addr_add),
      .write        (write_add),
      .wdata        (wdata_add),
      .result_valid (result_valid),
      .result       (result),
      .busy         (busy)
   );

   alut_age_checker #(.depth(depth)) u_age_checker (
      .pclk17    (pclk17),
      .rst_n     (rst_n),
      .age_en    (age_en),
      .max_age   (max_age),
      .busy      (busy),       // pauses the sweep
      .rdata     (rdata_age),
      .addr      (addr_age),
      .write     (write_age),
      .wdata     (wdata_age),
      .curr_time (curr_time),
      .ready     (ready)
   );

endmodule

//--- hw/alut_age_checker.sv
// age checker: clears the table after reset, keeps the time counter, invalidates stale entries
module alut_age_checker #(
   parameter int depth = 256                            // table entries
) (
   input  logic                        pclk17,
   input  logic                        rst_n,
   input  logic                        age_en,          // aging sweep enable
   input  logic [alut_pkg::time_w-1:0] max_age,         // aging limit in cycles
   input  logic                        busy,            // address checker owns the table
   input  alut_pkg::alut_entry_t       rdata,
   output logic [alut_pkg::hash_w-1:0] addr,
   output logic                        write,
   output alut_pkg::alut_entry_t       wdata,
   output logic [alut_pkg::time_w-1:0] curr_time,
   output logic                        ready            // clear sweep finished
);
   import alut_pkg::*;

   typedef enum logic [1:0]
   {
      st_clear,   // zero one entry per cycle
      st_read,    // sweep address on the port
      st_exam,    // entry back, check its age
      st_write    // write back with valid cleared
   } state_t;

   state_t            state;
   logic [time_w-1:0] elapsed;
   logic              expired;
   logic              last;

   assign last    = (addr == hash_w'(depth - 1));   // sweep wraps here
   assign elapsed = curr_time - rdata.stamp;        // wraps cleanly, unsigned
   assign expired = rdata.valid && (elapsed > max_age);

   // ------------------------------------------------------------------------
   // time counter
   // ------------------------------------------------------------------------
   always_ff @(posedge pclk17 or negedge rst_n)
   begin
      if (!rst_n)
         curr_time <= '0;
      else
         curr_time <= curr_time + 1'b1;
   end

   // ------------------------------------------------------------------------
   // clear and aging sweep
   // ------------------------------------------------------------------------
   always_ff @(posedge pclk17 or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state <= st_clear;
         addr  <= '0;
         ready <= 1'b0;
      end
      else
      begin
         case (state)
            st_clear:
            begin
               addr <= last ? '0 : addr + 1'b1;
               if (last)
               begin
                  ready <= 1'b1;   // stays up until next reset
                  state <= st_read;
               end
            end
            st_read:
               if (age_en && !busy) state <= st_exam;
            st_exam:
               if (busy)
                  state <= st_read;   // learn may change it, re-read
               else if (expired)
                  state <= st_write;
               else
               begin
                  addr  <= last ? '0 : addr + 1'b1;
                  state <= st_read;
               end
            default:   // st_write
            begin
               if (!busy)
                  addr <= last ? '0 : addr + 1'b1;   // else retry same address
               state <= st_read;
            end
         endcase
      end
   end

   // ------------------------------------------------------------------------
   // memory port, silent while busy
   // ------------------------------------------------------------------------
   assign write = (state == st_clear) || ((state == st_write) && !busy);

   always_comb
   begin
      wdata       = rdata;   // rdata holds during the write
      wdata.valid = 1'b0;
      if (state == st_clear)
         wdata = '0;
   end

endmodule

//--- hw/alut_addr_checker.sv
// address checker: looks up the destination MAC, learns the source MAC, strobes the result
module alut_addr_checker (
   input  logic                        pclk17,
   input  logic                        rst_n,
   input  logic                        check_req,   // one-cycle request strobe
   input  alut_pkg::alut_req_t         req,         // valid with check_req
   input  logic                        ready,       // table cleared
   input  logic [alut_pkg::time_w-1:0] curr_time,   // stamp for learned entries
   input  alut_pkg::alut_entry_t       rdata,       // memory read data
   output logic [alut_pkg::hash_w-1:0] addr,
   output logic                        write,
   output alut_pkg::alut_entry_t       wdata,
   output logic                        result_valid,
   output alut_pkg::alut_result_t      result,
   output logic                        busy
);
   import alut_pkg::*;

   // ------------------------------------------------------------------------
   // sequencer states
   // ------------------------------------------------------------------------
   typedef enum logic [1:0]
   {
      st_idle,   // waiting for a request
      st_rd,     // dst hash on the port
      st_cmp,    // read data back, compare
      st_lrn     // write source entry
   } state_t;

   state_t    state;
   alut_req_t req_q;    // request held for the whole sequence
   logic      accept;
   logic      hit;

   // requests while busy or before the clear sweep are dropped
   assign accept = check_req && ready && (state == st_idle);

   assign busy = (state != st_idle);   // also pauses the age sweep

   // ------------------------------------------------------------------------
   // state register
   // ------------------------------------------------------------------------
   always_ff @(posedge pclk17 or negedge rst_n)
   begin
      if (!rst_n)
         state <= st_idle;
      else
      begin
         case (state)
            st_idle: if (accept) state <= st_rd;
            st_rd:   state <= st_cmp;
            st_cmp:  state <= st_lrn;
            default: state <= st_idle;   // st_lrn, write done this cycle
         endcase
      end
   end

   // payload, captured on accept only
   always_ff @(posedge pclk17)
   begin
      if (accept)
         req_q <= req;
   end

   // ------------------------------------------------------------------------
   // memory port
   // ------------------------------------------------------------------------
   // dst hash while reading, src hash while learning
   assign addr  = (state == st_lrn) ? alut_hash(req_q.src_mac) : alut_hash(req_q.dst_mac);
   assign write = (state == st_lrn);

   always_comb
   begin
      wdata.valid = 1'b1;
      wdata.stamp = curr_time;          // learn time
      wdata.port  = req_q.src_port;
      wdata.mac   = req_q.src_mac;
   end

   // ------------------------------------------------------------------------
   // compare and result
   // ------------------------------------------------------------------------
   assign hit = rdata.valid && (rdata.mac == req_q.dst_mac);   // full MAC, not just hash

   always_ff @(posedge pclk17 or negedge rst_n)
   begin
      if (!rst_n)
         result_valid <= 1'b0;
      else
         result_valid <= (state == st_cmp);   // high during the learn cycle
   end

   always_ff @(posedge pclk17)
   begin
      if (state == st_cmp)
      begin
         result.hit  <= hit;
         result.port <= hit ? rdata.port : '0;   // port 0 on a miss
      end
   end

endmodule

//--- hw/alut_mem.sv
// dual-port entry RAM of the lookup table, one port per checker, read latency one cycle
module alut_mem #(
   parameter int depth = 256                          // table entries
) (
   input  logic                        pclk17,
   input  logic [alut_pkg::hash_w-1:0] addr_add,      // address checker port
   input  logic                        write_add,     // high writes, low reads
   input  alut_pkg::alut_entry_t       wdata_add,
   input  logic [alut_pkg::hash_w-1:0] addr_age,      // age checker port
   input  logic                        write_age,
   input  alut_pkg::alut_entry_t       wdata_age,
   output alut_pkg::alut_entry_t       rdata_add,     // valid one cycle after addr
   output alut_pkg::alut_entry_t       rdata_age
);
   import alut_pkg::*;

   alut_entry_t mem [depth];   // one entry per hash value

   // ------------------------------------------------------------------------
   // two independent ports on one array
   // ------------------------------------------------------------------------
   always_ff @(posedge pclk17)
   begin
      if (write_add)
         mem[addr_add] <= wdata_add;   // learn
      else
         rdata_add <= mem[addr_add];   // lookup read that holds on write

      if (write_age)
         mem[addr_age] <= wdata_age;   // clear or invalidate
      else
         rdata_age <= mem[addr_age];   // sweep read
   end

endmodule

//--- hw/alut_pkg.sv
// shared widths, entry/request/result structs and the table hash for the MAC lookup table
package alut_pkg;

   // ------------------------------------------------------------------------
   // widths
   // ------------------------------------------------------------------------
   localparam int mac_w  = 48;   // ethernet MAC address
   localparam int port_w = 2;    // four switch ports
   localparam int time_w = 32;   // free-running timestamp
   localparam int hash_w = 8;    // table address, matches depth 256

   // ------------------------------------------------------------------------
   // memory word, 83 bits
   // ------------------------------------------------------------------------
   typedef struct packed
   {
      logic              valid;  // entry holds a learned address
      logic [time_w-1:0] stamp;  // time of last learn
      logic [port_w-1:0] port;   // port the source was seen on
      logic [mac_w-1:0]  mac;    // full MAC, compared on lookup
   } alut_entry_t;

   // one lookup request, sampled with check_req
   typedef struct packed
   {
      logic [mac_w-1:0]  dst_mac;   // looked up
      logic [mac_w-1:0]  src_mac;   // learned
      logic [port_w-1:0] src_port;  // ingress port of the frame
   } alut_req_t;

   // lookup answer
   typedef struct packed
   {
      logic              hit;    // dst found and valid
      logic [port_w-1:0] port;   // 0 on a miss
   } alut_result_t;

   // ------------------------------------------------------------------------
   // hash: xor-fold of the six MAC bytes
   // ------------------------------------------------------------------------
   function automatic logic [hash_w-1:0] alut_hash(input logic [mac_w-1:0] mac);
      logic [hash_w-1:0] h;
      h = '0;
      for (int i = 0; i < mac_w / hash_w; i++)
      begin
         h = h ^ mac[i*hash_w +: hash_w];   // fold one byte in
      end
      return h;
   endfunction

   // direct-mapped table, so a collision simply replaces the
   // older entry at that index; no chaining or buckets

endpackage
